// ==== dma_core.f ====
+incdir+hdl
hdl/dma_pkg.sv
hdl/ctrl_arbiter.sv
hdl/trans_allocator.sv
hdl/xfer_fsm.sv
hdl/xfer_counter.sv
hdl/dma_core.sv
verification/dma_core_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
FILELIST   = dma_core.f
TB_TOP     = dma_core_tb
RTL_TOP    = dma_core
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -j 0
PASS_MSG   = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/dma_core_tb.sv ====
// DMA slot manager testbench
// Slot allocation, fairness, termination routing and back-pressure checks

`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_core_tb
   import dma_pkg::*;
();

   localparam int clk_period_ns = 8;
   localparam int max_len       = 31;                  // Random lengths use 5 bits
   localparam int nb_cmds       = 20;
   localparam int cmd_cycles    = max_len + 9;         // Run, done, delivery and handshake
   localparam int cycle_limit   = 4 * (nb_cmds * cmd_cycles + 200);

   logic                                         clk_i;
   logic                                         rst_ni;
   logic      [`DMA_NB_CTRLS-1:0]                trans_req_i;
   logic      [`DMA_NB_CTRLS-1:0]                trans_gnt_o;
   sid_t                                         trans_sid_o;
   logic      [`DMA_NB_CTRLS-1:0][`DMA_NB_SLOTS-1:0] trans_clr_i;
   logic      [`DMA_NB_SLOTS-1:0]                trans_status_o;
   logic                                         cmd_valid_i;
   logic                                         cmd_ready_o;
   sid_t                                         cmd_sid_i;
   cid_t                                         cmd_cid_i;
   len_t                                         cmd_len_i;
   logic                                         cmd_ele_i;
   logic                                         cmd_ile_i;
   logic                                         cmd_ble_i;
   logic      [`DMA_NB_CTRLS-1:0]                term_evt_o;
   logic      [`DMA_NB_CTRLS-1:0]                term_int_o;

   // Reference model state
   logic [`DMA_NB_SLOTS-1:0]   model_busy;
   int                         last_cid;
   sid_t                       last_sid;
   logic [2*`DMA_NB_CTRLS-1:0] exp_q [$];  // Expected {evt, int} in accept order
   logic [2*`DMA_NB_CTRLS-1:0] obs_vec;
   logic [2*`DMA_NB_CTRLS-1:0] exp_vec;
   logic [31:0]                rng;
   int                         errors;
   int                         checks;
   int                         err_mark;
   int                         tests_run;
   int                         tests_failed;
   int                         cycle_cnt;

   dma_core DUT (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .trans_req_i    (trans_req_i),
      .trans_gnt_o    (trans_gnt_o),
      .trans_sid_o    (trans_sid_o),
      .trans_clr_i    (trans_clr_i),
      .trans_status_o (trans_status_o),
      .cmd_valid_i    (cmd_valid_i),
      .cmd_ready_o    (cmd_ready_o),
      .cmd_sid_i      (cmd_sid_i),
      .cmd_cid_i      (cmd_cid_i),
      .cmd_len_i      (cmd_len_i),
      .cmd_ele_i      (cmd_ele_i),
      .cmd_ile_i      (cmd_ile_i),
      .cmd_ble_i      (cmd_ble_i),
      .term_evt_o     (term_evt_o),
      .term_int_o     (term_int_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(clk_period_ns / 2) clk_i = ~clk_i;
   end

   // **************************************************
   // Reference functions
   // **************************************************

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Expected {event, interrupt} vectors for one termination
   function automatic logic [2*`DMA_NB_CTRLS-1:0] exp_route(input cid_t cid, input logic ele,
                                                             input logic ile, input logic ble);
      logic [`DMA_NB_CTRLS-1:0] dest;
      logic [`DMA_NB_CTRLS-1:0] evt;
      logic [`DMA_NB_CTRLS-1:0] irq;
      dest = '0;
      if (ble)
         dest = '1;
      else
         dest[cid] = 1'b1;
      evt = ele ? dest : '0;
      irq = ile ? dest : '0;
      return {evt, irq};
   endfunction

   function automatic sid_t lowest_free(input logic [`DMA_NB_SLOTS-1:0] busy);
      logic found;
      found       = 1'b0;
      lowest_free = '0;
      for (int k = 0; k < `DMA_NB_SLOTS; k++)
      begin
         if (!busy[k] && !found)
         begin
            lowest_free = sid_t'(k);
            found       = 1'b1;
         end
      end
   endfunction

   // First requester after the last granted controller
   function automatic int rr_pick(input logic [`DMA_NB_CTRLS-1:0] req, input int last);
      int idx;
      rr_pick = last;
      for (int k = `DMA_NB_CTRLS; k >= 1; k--)
      begin
         idx = (last + k) % `DMA_NB_CTRLS;
         if (req[idx])
            rr_pick = idx;
      end
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (errors == err_mark)
         $display("Test %0d (%s): passed", tests_run, name);
      else
      begin
         tests_failed++;
         $display("Test %0d (%s): failed with %0d errors", tests_run, name, errors - err_mark);
      end
      err_mark = errors;
   endtask

   // **************************************************
   // Stimulus tasks
   // **************************************************

   // One cycle of slot requests and clears, checked against the model
   task automatic slot_cycle(input logic [`DMA_NB_CTRLS-1:0] req,
                             input logic [`DMA_NB_CTRLS-1:0][`DMA_NB_SLOTS-1:0] clr);
      logic [`DMA_NB_CTRLS-1:0] exp_gnt;
      logic [`DMA_NB_SLOTS-1:0] clr_any;
      int                       win;
      @(negedge clk_i);
      trans_req_i = req;
      trans_clr_i = clr;
      @(posedge clk_i);
      check(trans_status_o, model_busy, "slot status");
      exp_gnt = '0;
      win     = rr_pick(req, last_cid);
      if (req != '0 && !(&model_busy))
         exp_gnt[win] = 1'b1;
      check(trans_gnt_o, exp_gnt, "slot grant");
      clr_any = '0;
      for (int c = 0; c < `DMA_NB_CTRLS; c++)
         clr_any = clr_any | clr[c];
      if (exp_gnt != '0)
      begin
         check(trans_sid_o, lowest_free(model_busy), "granted SID");
         last_sid                         = trans_sid_o;  // SID seen on the port
         model_busy[lowest_free(model_busy)] = 1'b1;
         last_cid                         = win;
      end
      model_busy = model_busy & ~clr_any;  // Clear wins over set
   endtask

   task automatic offer_cmd(input sid_t sid, input cid_t cid, input len_t len, input logic ele,
                            input logic ile, input logic ble, output int waited);
      @(negedge clk_i);
      cmd_valid_i = 1'b1;
      cmd_sid_i   = sid;
      cmd_cid_i   = cid;
      cmd_len_i   = len;
      cmd_ele_i   = ele;
      cmd_ile_i   = ile;
      cmd_ble_i   = ble;
      waited      = 0;
      @(posedge clk_i);
      while (!cmd_ready_o)
      begin
         waited++;
         @(posedge clk_i);
      end
   endtask

   // Wait for the engine to go idle and the pulse to be delivered
   task automatic finish_cmd();
      @(negedge clk_i);
      cmd_valid_i = 1'b0;
      @(posedge clk_i);
      while (!cmd_ready_o)
         @(posedge clk_i);
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      check(exp_q.size(), 0, "termination pulses missing");
   endtask

   task automatic random_cmd(input logic bcast);
      int waited;
      rng = xorshift32(rng);
      offer_cmd(sid_t'(rng[1:0]), cid_t'(rng[2]), len_t'(rng[12:8]), rng[3], rng[4], bcast,
                waited);
      check(waited, 0, "wait on an idle engine");
      finish_cmd();
   endtask

   // **************************************************
   // Monitor
   // **************************************************

   always @(posedge clk_i)
   begin
      if (rst_ni)
      begin
         obs_vec = {term_evt_o, term_int_o};
         if (obs_vec != '0)
         begin
            if (exp_q.size() == 0)
               check(obs_vec, '0, "unexpected termination pulse");
            else
            begin
               exp_vec = exp_q.pop_front();
               check(obs_vec, exp_vec, "termination pulse {evt, int}");
            end
         end
         // Accepted command queued after the pulse of the previous one
         if (cmd_valid_i && cmd_ready_o)
         begin
            exp_vec = exp_route(cmd_cid_i, cmd_ele_i, cmd_ile_i, cmd_ble_i);
            if (exp_vec != '0)
               exp_q.push_back(exp_vec);
         end
      end
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
   end

   // **************************************************
   // Test sequence
   // **************************************************

   initial
   begin
      logic [`DMA_NB_CTRLS-1:0][`DMA_NB_SLOTS-1:0] clr_v;
      int                                           waited;
      int                                           len_a;
      rst_ni       = 1'b0;
      trans_req_i  = '0;
      trans_clr_i  = '0;
      cmd_valid_i  = 1'b0;
      cmd_sid_i    = '0;
      cmd_cid_i    = '0;
      cmd_len_i    = '0;
      cmd_ele_i    = 1'b0;
      cmd_ile_i    = 1'b0;
      cmd_ble_i    = 1'b0;
      model_busy   = '0;
      last_cid     = `DMA_NB_CTRLS - 1;  // Controller 0 wins first
      last_sid     = '0;
      rng          = 32'h7c9a_9230;
      errors       = 0;
      checks       = 0;
      err_mark     = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;

      // Allocation order
      @(posedge clk_i);
      check({term_evt_o, term_int_o, trans_gnt_o}, '0, "outputs after reset");
      for (int k = 0; k < `DMA_NB_SLOTS; k++)
         slot_cycle(2'b01 << (k % `DMA_NB_CTRLS), '0);
      slot_cycle('0, '0);
      report_test("allocation order");

      // Exhaustion, then slot 2 freed for the waiting controller
      repeat (3) slot_cycle(2'b10, '0);
      clr_v    = '0;
      clr_v[0] = 4'b0100;
      slot_cycle(2'b10, clr_v);
      slot_cycle(2'b10, '0);
      check(last_sid, 2, "SID after clear");
      slot_cycle('0, '0);
      report_test("exhaustion and clear");

      // Fairness with both controllers requesting
      clr_v    = '0;
      clr_v[1] = '1;
      slot_cycle('0, clr_v);
      repeat (`DMA_NB_SLOTS) slot_cycle(2'b11, '0);
      slot_cycle('0, '0);
      report_test("fairness");

      // Unicast routing
      repeat (12) random_cmd(1'b0);
      report_test("unicast routing");

      // Broadcast routing, first with both enables clear
      offer_cmd(sid_t'(3), cid_t'(1), len_t'(5), 1'b0, 1'b0, 1'b1, waited);
      finish_cmd();
      repeat (5) random_cmd(1'b1);
      report_test("broadcast routing");

      // Back-pressure behind a running transfer
      rng   = xorshift32(rng);
      len_a = 20;
      offer_cmd(sid_t'(0), cid_t'(0), len_t'(len_a), 1'b1, 1'b0, 1'b0, waited);
      offer_cmd(sid_t'(1), cid_t'(1), len_t'(rng[12:8]), 1'b1, 1'b1, 1'b0, waited);
      check(waited, len_a + 2, "cycles the second command waited");  // Run plus done
      finish_cmd();
      report_test("back-pressure");

      $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/dma_core.sv ====
// DMA slot manager top level
// Connects arbiter, slot allocator, transfer FSM and beat counter

`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module dma_core import dma_pkg::*;
(
   input  wire logic                                         clk_i,
   input  wire logic                                         rst_ni,
   // Slot requests
   input  wire logic [`DMA_NB_CTRLS-1:0]                     trans_req_i,
   output logic      [`DMA_NB_CTRLS-1:0]                     trans_gnt_o,
   output sid_t                                              trans_sid_o,
   input  wire logic [`DMA_NB_CTRLS-1:0][`DMA_NB_SLOTS-1:0] trans_clr_i,
   output logic      [`DMA_NB_SLOTS-1:0]                     trans_status_o,
   // Command port
   input  wire logic                                         cmd_valid_i,
   output logic                                              cmd_ready_o,
   input  sid_t                                              cmd_sid_i,
   input  cid_t                                              cmd_cid_i,
   input  len_t                                              cmd_len_i,
   input  wire logic                                         cmd_ele_i,
   input  wire logic                                         cmd_ile_i,
   input  wire logic                                         cmd_ble_i,
   // Termination pulses
   output logic      [`DMA_NB_CTRLS-1:0]                     term_evt_o,
   output logic      [`DMA_NB_CTRLS-1:0]                     term_int_o
);

   logic                     arb_req;
   logic                     arb_gnt;
   cid_t                     arb_cid;
   logic                     cmd_acc;
   logic                     cnt_load;
   len_t                     cnt_len;
   logic                     cnt_last;
   logic [`DMA_NB_SLOTS-1:0] term_sig;

   ctrl_arbiter u_arbiter (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (trans_req_i),
      .gnt_o  (trans_gnt_o),
      .req_o  (arb_req),
      .gnt_i  (arb_gnt),
      .id_o   (arb_cid)
   );

   trans_allocator u_allocator (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .arb_req_i      (arb_req),
      .arb_cid_i      (arb_cid),
      .arb_gnt_o      (arb_gnt),
      .trans_sid_o    (trans_sid_o),
      .trans_clr_i    (trans_clr_i),
      .trans_status_o (trans_status_o),
      .cmd_acc_i      (cmd_acc),
      .cmd_sid_i      (cmd_sid_i),
      .cmd_cid_i      (cmd_cid_i),
      .cmd_ele_i      (cmd_ele_i),
      .cmd_ile_i      (cmd_ile_i),
      .cmd_ble_i      (cmd_ble_i),
      .term_sig_i     (term_sig),
      .term_evt_o     (term_evt_o),
      .term_int_o     (term_int_o)
   );

   // Single transfer engine
   xfer_fsm u_fsm (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_o (cmd_ready_o),
      .cmd_sid_i   (cmd_sid_i),
      .cmd_len_i   (cmd_len_i),
      .cmd_acc_o   (cmd_acc),
      .cnt_load_o  (cnt_load),
      .cnt_len_o   (cnt_len),
      .cnt_last_i  (cnt_last),
      .term_sig_o  (term_sig)
   );

   xfer_counter u_counter (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .load_i (cnt_load),
      .len_i  (cnt_len),
      .last_o (cnt_last)
   );

endmodule

`default_nettype wire

// ==== hdl/xfer_counter.sv ====
// Beat counter
// Loadable down-counter flagging the last beat

`timescale 1ns/1ps
`default_nettype none

module xfer_counter import dma_pkg::*;
(
   input  wire logic clk_i,
   input  wire logic rst_ni,
   input  wire logic load_i,
   input  len_t      len_i,
   output logic      last_o
);

   len_t cnt_q;  // Beats left

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         cnt_q <= '0;
      end
      else if (load_i)
      begin
         cnt_q <= len_i;
      end
      else if (cnt_q != '0)
      begin
         cnt_q <= cnt_q - len_t'(1);  // One beat per cycle
      end
   end

   // Zero count with no fresh load pending
   assign last_o = (cnt_q == '0) && !load_i;

endmodule

`default_nettype wire

// ==== hdl/xfer_fsm.sv ====
// Transfer engine FSM
// Accepts one command at a time and signals its termination

`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module xfer_fsm import dma_pkg::*;
(
   input  wire logic                     clk_i,
   input  wire logic                     rst_ni,
   // Command port
   input  wire logic                     cmd_valid_i,
   output logic                          cmd_ready_o,
   input  sid_t                          cmd_sid_i,
   input  len_t                          cmd_len_i,
   output logic                          cmd_acc_o,
   // Beat counter
   output logic                          cnt_load_o,
   output len_t                          cnt_len_o,
   input  wire logic                     cnt_last_i,
   // One-hot termination by SID
   output logic      [`DMA_NB_SLOTS-1:0] term_sig_o
);

   xfer_state_e state_q;
   xfer_state_e state_d;
   sid_t        sid_q;  // SID of the running transfer

   assign cmd_ready_o = (state_q == XFER_IDLE);
   assign cmd_acc_o   = cmd_valid_i & cmd_ready_o;

   // Counter loads on the accept edge
   assign cnt_load_o = cmd_acc_o;
   assign cnt_len_o  = cmd_len_i;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         XFER_IDLE:
         begin
            if (cmd_acc_o)
               state_d = XFER_RUN;
         end
         XFER_RUN:
         begin
            if (cnt_last_i)
               state_d = XFER_DONE;
         end
         XFER_DONE: state_d = XFER_IDLE;  // Single cycle
         default:   state_d = XFER_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         state_q <= XFER_IDLE;
      else
         state_q <= state_d;
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_acc_o)
         sid_q <= cmd_sid_i;
   end

   // Termination pulse during XFER_DONE
   always_comb
   begin
      term_sig_o = '0;
      term_sig_o[sid_q] = (state_q == XFER_DONE);
   end

endmodule

`default_nettype wire

// ==== hdl/trans_allocator.sv ====
// Transfer slot allocator
// Busy table, SID grant, termination buffering and event/interrupt routing

`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module trans_allocator import dma_pkg::*;
(
   input  wire logic                                         clk_i,
   input  wire logic                                         rst_ni,
   // Arbiter side
   input  wire logic                                         arb_req_i,
   input  cid_t                                              arb_cid_i,
   output logic                                              arb_gnt_o,
   output sid_t                                              trans_sid_o,
   // Clear and status
   input  wire logic [`DMA_NB_CTRLS-1:0][`DMA_NB_SLOTS-1:0] trans_clr_i,
   output logic      [`DMA_NB_SLOTS-1:0]                     trans_status_o,
   // Accepted command
   input  wire logic                                         cmd_acc_i,
   input  sid_t                                              cmd_sid_i,
   input  cid_t                                              cmd_cid_i,
   input  wire logic                                         cmd_ele_i,
   input  wire logic                                         cmd_ile_i,
   input  wire logic                                         cmd_ble_i,
   // Termination
   input  wire logic [`DMA_NB_SLOTS-1:0]                     term_sig_i,
   output logic      [`DMA_NB_CTRLS-1:0]                     term_evt_o,
   output logic      [`DMA_NB_CTRLS-1:0]                     term_int_o
);

   logic [`DMA_NB_SLOTS-1:0] busy_q;
   logic [`DMA_NB_SLOTS-1:0] set_vec;
   logic [`DMA_NB_SLOTS-1:0] clr_vec;
   sid_t                     free_sid;
   logic                     alloc;

   // Per-slot termination info
   cid_t                     cid_mem [`DMA_NB_SLOTS];
   logic [`DMA_NB_SLOTS-1:0] ele_mem;
   logic [`DMA_NB_SLOTS-1:0] ile_mem;
   logic [`DMA_NB_SLOTS-1:0] ble_mem;

   // Buffered terminations
   logic [`DMA_NB_SLOTS-1:0] pend_q;
   cid_t                     cid_buf [`DMA_NB_SLOTS];
   logic [`DMA_NB_SLOTS-1:0] ele_buf;
   logic [`DMA_NB_SLOTS-1:0] ile_buf;
   logic [`DMA_NB_SLOTS-1:0] ble_buf;
   logic [`DMA_NB_SLOTS-1:0] ser;
   sid_t                     ser_sid;
   logic                     ser_vld;

   // **************************************************
   // Slot grant and busy table
   // **************************************************

   // Lowest free slot wins
   always_comb
   begin
      free_sid = '0;
      for (int k = `DMA_NB_SLOTS - 1; k >= 0; k--)
      begin
         if (!busy_q[k])
            free_sid = sid_t'(k);
      end
   end

   assign arb_gnt_o   = ~&busy_q;                    // Any slot left
   assign trans_sid_o = free_sid;
   assign alloc       = arb_req_i & arb_gnt_o;

   // Clears from all controllers merge into one vector
   always_comb
   begin
      clr_vec = '0;
      for (int c = 0; c < `DMA_NB_CTRLS; c++)
         clr_vec = clr_vec | trans_clr_i[c];
   end

   always_comb
   begin
      set_vec = '0;
      set_vec[free_sid] = alloc;
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         busy_q <= '0;
      else
         busy_q <= (busy_q | set_vec) & ~clr_vec;  // Clear beats set
   end

   assign trans_status_o = busy_q;

   // **************************************************
   // Termination info per slot
   // **************************************************

   // Fields recorded when the command is accepted
   always_ff @(posedge clk_i)
   begin
      if (cmd_acc_i)
      begin
         cid_mem[cmd_sid_i] <= cmd_cid_i;
         ele_mem[cmd_sid_i] <= cmd_ele_i;
         ile_mem[cmd_sid_i] <= cmd_ile_i;
         ble_mem[cmd_sid_i] <= cmd_ble_i;
      end
   end

   // **************************************************
   // Termination buffer and delivery
   // **************************************************

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         pend_q <= '0;
      else
         pend_q <= term_sig_i | (pend_q & ~ser);  // Held until delivered
   end

   always_ff @(posedge clk_i)
   begin
      for (int k = 0; k < `DMA_NB_SLOTS; k++)
      begin
         if (term_sig_i[k])
         begin
            cid_buf[k] <= cid_mem[k];
            ele_buf[k] <= ele_mem[k];
            ile_buf[k] <= ile_mem[k];
            ble_buf[k] <= ble_mem[k];
         end
      end
   end

   // One delivery per cycle, lowest pending slot first
   always_comb
   begin
      ser     = '0;
      ser_sid = '0;
      ser_vld = 1'b0;
      for (int k = `DMA_NB_SLOTS - 1; k >= 0; k--)
      begin
         if (pend_q[k])
         begin
            ser_sid = sid_t'(k);
            ser_vld = 1'b1;
         end
      end
      ser[ser_sid] = ser_vld;
   end

   // Broadcast reaches every controller, otherwise only the stored CID
   always_comb
   begin
      term_evt_o = '0;
      term_int_o = '0;
      for (int c = 0; c < `DMA_NB_CTRLS; c++)
      begin
         if (ser_vld && (ble_buf[ser_sid] || (cid_buf[ser_sid] == cid_t'(c))))
         begin
            term_evt_o[c] = ele_buf[ser_sid];
            term_int_o[c] = ile_buf[ser_sid];
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/ctrl_arbiter.sv ====
// Controller arbiter
// Round-robin choice of one slot request per cycle

`timescale 1ns/1ps
`default_nettype none

`include "dma_cfg.svh"

module ctrl_arbiter import dma_pkg::*;
(
   input  wire logic                     clk_i,
   input  wire logic                     rst_ni,
   input  wire logic [`DMA_NB_CTRLS-1:0] req_i,
   output logic      [`DMA_NB_CTRLS-1:0] gnt_o,
   output logic                          req_o,
   input  wire logic                     gnt_i,
   output cid_t                          id_o
);

   cid_t        last_q;  // Last granted controller
   cid_t        sel;
   logic        found;
   int unsigned idx;

   // Search starts just after the last winner
   always_comb
   begin
      sel   = last_q;
      found = 1'b0;
      idx   = 0;
      for (int k = 1; k <= `DMA_NB_CTRLS; k++)
      begin
         idx = (int'(last_q) + k) % `DMA_NB_CTRLS;
         if (!found && req_i[idx])
         begin
            sel   = cid_t'(idx);
            found = 1'b1;
         end
      end
   end

   assign req_o = |req_i;
   assign id_o  = sel;

   // Grant goes back to the winner only
   always_comb
   begin
      gnt_o      = '0;
      gnt_o[sel] = req_o & gnt_i;
   end

   // Pointer moves only on an accepted grant
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         last_q <= cid_t'(`DMA_NB_CTRLS - 1);  // Controller 0 wins first
      end
      else if (req_o && gnt_i)
      begin
         last_q <= sel;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/dma_pkg.sv ====
// DMA slot manager types
// Transfer engine state and field vector types

`default_nettype none

`include "dma_cfg.svh"

package dma_pkg;

   // Slot, controller and length fields
   typedef logic [`DMA_SID_W-1:0] sid_t;
   typedef logic [`DMA_CID_W-1:0] cid_t;
   typedef logic [`DMA_LEN_W-1:0] len_t;

   // Transfer engine states
   typedef enum logic [1:0]
   {
      XFER_IDLE = 2'd0,  // Waiting for a command
      XFER_RUN  = 2'd1,  // Counting beats
      XFER_DONE = 2'd2   // Termination cycle
   } xfer_state_e;

endpackage

`default_nettype wire

// ==== hdl/dma_cfg.svh ====
// DMA slot manager configuration
// Controller count, slot count and field widths

`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Number of controllers sharing the engine
`define DMA_NB_CTRLS 2

`define DMA_NB_SLOTS 4  // Transfer slots

// Field widths
`define DMA_SID_W ($clog2(`DMA_NB_SLOTS))
`define DMA_CID_W ($clog2(`DMA_NB_CTRLS))
`define DMA_LEN_W 8     // Beat length

`endif
